// ==== resp_switch.f ====
rtl/resp_switch_pkg.sv
rtl/resp_fifo.sv
rtl/resp_route_lock.sv
rtl/resp_demux.sv
rtl/resp_switch_1_to_m.sv
verification/tb_resp_switch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the response switch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --timescale 1ns/1ps \
  --top-module tb_resp_switch \
  -f resp_switch.f \
  -o tb_resp_switch

./obj_dir/tb_resp_switch | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: the testbench reported a failure"
  exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
  echo "run_sim: the run ended without a result line"
  exit 1
fi

echo "run_sim: done"

// ==== verification/tb_resp_switch.sv ====
// testbench with clock, reset, random bursts, back-pressure and per-master model queues
`timescale 1ns/1ps

module tb_resp_switch
  import resp_switch_pkg::*;
();
  localparam int BEAT_W         = 1 + ID_W + DATA_W;  // {last, id, data} as kept in the model
  localparam int BURSTS         = 400;
  localparam int TIMEOUT_CYCLES = BURSTS * 4 * 8 + 1000;
  localparam int DRAIN_LIMIT    = 200;
  localparam int STALL_CYCLES   = 200;

  // accept modes per master
  localparam int ACC_RANDOM = 0;
  localparam int ACC_HIGH   = 1;
  localparam int ACC_LOW    = 2;

  logic                     clk;
  logic                     rst;
  logic                     sresp_valid;
  logic                     sresp_accept;
  resp_id_t                 sresp_id;
  resp_data_t               sresp_data;
  logic                     sresp_last;
  master_sel_t              mresp_valid;
  master_sel_t              mresp_accept;
  resp_id_t   [MASTERS-1:0] mresp_id;
  resp_data_t [MASTERS-1:0] mresp_data;
  logic       [MASTERS-1:0] mresp_last;

  logic [BEAT_W-1:0] exp_q [MASTERS][$];  // expected beats per master, in slave order
  int                accept_mode [MASTERS];
  logic              in_burst [MASTERS];
  resp_id_t          burst_id [MASTERS];
  int                errors;
  int                beats_checked;
  int                cycle_count;
  logic              stall_phase;
  logic              stall_seen;

  resp_switch_1_to_m i_resp_switch_1_to_m (
    .i_clk          (clk          ),
    .i_rst          (rst          ),
    .i_sresp_valid  (sresp_valid  ),
    .o_sresp_accept (sresp_accept ),
    .i_sresp_id     (sresp_id     ),
    .i_sresp_data   (sresp_data   ),
    .i_sresp_last   (sresp_last   ),
    .o_mresp_valid  (mresp_valid  ),
    .i_mresp_accept (mresp_accept ),
    .o_mresp_id     (mresp_id     ),
    .o_mresp_data   (mresp_data   ),
    .o_mresp_last   (mresp_last   )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  function automatic int pending_beats();
    int total;
    total = 0;
    for (int i = 0; i < MASTERS; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  // master accepts change 1 ns after each rising edge
  task automatic run_accepts();
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < MASTERS; i++) begin
        case (accept_mode[i])
          ACC_HIGH: mresp_accept[i] = 1'b1;
          ACC_LOW:  mresp_accept[i] = 1'b0;
          default:  mresp_accept[i] = ($urandom_range(99) < 70);  // about 70 percent
        endcase
      end
    end
  endtask

  // holds the beat until the slave accept seen before an edge says it went through
  task automatic send_beat(input resp_id_t id, input resp_data_t data, input logic last);
    logic accepted;
    sresp_valid = 1'b1;
    sresp_id    = id;
    sresp_data  = data;
    sresp_last  = last;
    do begin
      @(negedge clk);
      accepted = sresp_accept;
      @(posedge clk);
      #1;
    end while (!accepted);
  endtask

  task automatic send_burst(input int dest, input bit gaps);
    int          len;
    int          gap;
    logic [ID_W-MASTER_IDX_W-1:0] tag;
    resp_id_t    id;
    len = int'($urandom_range(4, 1));
    tag = (ID_W-MASTER_IDX_W)'($urandom);
    id  = {master_idx_t'(dest), tag};  // destination and tag stay fixed for the whole burst
    for (int b = 0; b < len; b++) begin
      if (gaps) begin
        gap = int'($urandom_range(3));
        if (gap != 0) begin
          sresp_valid = 1'b0;
        end
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      send_beat(id, resp_data_t'($urandom), b == len - 1);
    end
    sresp_valid = 1'b0;
  endtask

  // the model follows the bus at the falling edge, where every signal is settled
  initial begin
    logic [BEAT_W-1:0] expected_beat;
    int                dest;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (sresp_valid && sresp_accept) begin
          dest = int'(sresp_id[ID_W-1 -: MASTER_IDX_W]);
          exp_q[dest].push_back({sresp_last, sresp_id, sresp_data});
        end
        if (stall_phase && !sresp_accept) begin
          stall_seen = 1'b1;
        end
        for (int i = 0; i < MASTERS; i++) begin
          if (mresp_valid[i] && mresp_accept[i]) begin
            beats_checked++;
            check_value($sformatf("m%0d_dest", i), 64'(i),
                        64'(mresp_id[i][ID_W-1 -: MASTER_IDX_W]));
            if (exp_q[i].size() == 0) begin
              errors++;
              $display("Error: master %0d delivered a beat that was never sent to it", i);
            end else begin
              expected_beat = exp_q[i].pop_front();
              check_value($sformatf("m%0d_id", i), 64'(expected_beat[DATA_W +: ID_W]),
                          64'(mresp_id[i]));
              check_value($sformatf("m%0d_data", i), 64'(expected_beat[DATA_W-1:0]),
                          64'(mresp_data[i]));
              check_value($sformatf("m%0d_last", i), 64'(expected_beat[BEAT_W-1]),
                          64'(mresp_last[i]));
              // later beats of a burst keep the id of its first beat on the same port
              if (in_burst[i]) begin
                check_value($sformatf("m%0d_burst_id", i), 64'(burst_id[i]),
                            64'(mresp_id[i]));
              end
              in_burst[i] = !expected_beat[BEAT_W-1];
              burst_id[i] = expected_beat[DATA_W +: ID_W];
            end
          end
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks done: %0d beats checked, %0d errors", beats_checked, errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int stall_master;
    int drain_cycles;
    void'($urandom(32'h35b9b7bb));
    rst           = 1'b1;
    sresp_valid   = 1'b0;
    sresp_id      = '0;
    sresp_data    = '0;
    sresp_last    = 1'b0;
    mresp_accept  = '0;
    errors        = 0;
    beats_checked = 0;
    stall_phase   = 1'b0;
    stall_seen    = 1'b0;
    for (int i = 0; i < MASTERS; i++) begin
      accept_mode[i] = ACC_RANDOM;
      in_burst[i]    = 1'b0;
      burst_id[i]    = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    check_value("reset_mresp_valid", 64'(0), 64'(mresp_valid));
    check_value("reset_sresp_accept", 64'(1), 64'(sresp_accept));
    @(posedge clk);
    #1;
    fork
      run_accepts();
    join_none

    // random traffic with random back-pressure on every master
    for (int n = 0; n < BURSTS / 2; n++) begin
      send_burst(int'($urandom_range(MASTERS - 1)), 1'b1);
    end

    // one master stalls while traffic keeps coming
    stall_master = int'($urandom_range(MASTERS - 1));
    fork
      begin
        accept_mode[stall_master] = ACC_LOW;
        stall_phase = 1'b1;
        repeat (STALL_CYCLES) @(posedge clk);
        stall_phase = 1'b0;
        accept_mode[stall_master] = ACC_RANDOM;
      end
      begin
        for (int n = 0; n < BURSTS / 4; n++) begin
          send_burst(int'($urandom_range(MASTERS - 1)), 1'b1);
        end
      end
    join
    check_value("stall_sresp_accept_drop", 64'(1), 64'(stall_seen));

    // all masters accept and the slave sends back to back
    for (int i = 0; i < MASTERS; i++) begin
      accept_mode[i] = ACC_HIGH;
    end
    for (int n = 0; n < BURSTS / 4; n++) begin
      send_burst(int'($urandom_range(MASTERS - 1)), 1'b0);
    end

    drain_cycles = 0;
    while ((pending_beats() != 0) && (drain_cycles < DRAIN_LIMIT)) begin
      @(posedge clk);
      drain_cycles++;
    end
    for (int i = 0; i < MASTERS; i++) begin
      if (exp_q[i].size() != 0) begin
        errors++;
        $display("Error: master %0d never delivered %0d expected beats", i, exp_q[i].size());
      end
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("final_mresp_valid", 64'(0), 64'(mresp_valid));

    $display("Checks done: %0d beats checked, %0d errors", beats_checked, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end
endmodule

// ==== rtl/resp_switch_1_to_m.sv ====
// resp_switch_1_to_m: 1-to-MASTERS response switch with input FIFO, route lock and output FIFOs
`timescale 1ns/1ps

module resp_switch_1_to_m
  import resp_switch_pkg::*;
(
  input  var logic                     i_clk,
  input  var logic                     i_rst,
  input  var logic                     i_sresp_valid,
  output var logic                     o_sresp_accept,
  input  var resp_id_t                 i_sresp_id,
  input  var resp_data_t               i_sresp_data,
  input  var logic                     i_sresp_last,
  output var master_sel_t              o_mresp_valid,
  input  var master_sel_t              i_mresp_accept,
  output var resp_id_t   [MASTERS-1:0] o_mresp_id,
  output var resp_data_t [MASTERS-1:0] o_mresp_data,
  output var logic       [MASTERS-1:0] o_mresp_last
);
  logic        head_valid;
  logic        head_accept;
  resp_id_t    head_id;
  resp_data_t  head_data;
  logic        head_last;
  logic        head_transfer;

  master_sel_t route_request;
  master_sel_t route_grant;
  master_sel_t sw_valid;
  master_sel_t sw_accept;

  resp_fifo #(
    .DEPTH  (SLAVE_DEPTH)
  ) u_slave_fifo (
    .i_clk    (i_clk          ),
    .i_rst    (i_rst          ),
    .i_valid  (i_sresp_valid  ),
    .o_accept (o_sresp_accept ),
    .i_id     (i_sresp_id     ),
    .i_data   (i_sresp_data   ),
    .i_last   (i_sresp_last   ),
    .o_valid  (head_valid     ),
    .i_accept (head_accept    ),
    .o_id     (head_id        ),
    .o_data   (head_data      ),
    .o_last   (head_last      )
  );

  resp_demux u_demux (
    .i_head_valid   (head_valid     ),
    .o_head_accept  (head_accept    ),
    .i_head_id      (head_id        ),
    .o_request      (route_request  ),
    .i_grant        (route_grant    ),
    .o_sw_valid     (sw_valid       ),
    .i_sw_accept    (sw_accept      )
  );

  // the lock releases itself when a last beat leaves the head
  always_comb begin
    head_transfer = head_valid && head_accept;
  end

  resp_route_lock u_route_lock (
    .i_clk      (i_clk          ),
    .i_rst      (i_rst          ),
    .i_request  (route_request  ),
    .i_transfer (head_transfer  ),
    .i_last     (head_last      ),
    .o_grant    (route_grant    )
  );

  // every output FIFO sees the head payload, only the granted one sees valid
  for (genvar i = 0; i < MASTERS; i++) begin : g_master_fifo
    resp_fifo #(
      .DEPTH  (MASTER_DEPTH)
    ) u_master_fifo (
      .i_clk    (i_clk              ),
      .i_rst    (i_rst              ),
      .i_valid  (sw_valid[i]        ),
      .o_accept (sw_accept[i]       ),
      .i_id     (head_id            ),
      .i_data   (head_data          ),
      .i_last   (head_last          ),
      .o_valid  (o_mresp_valid[i]   ),
      .i_accept (i_mresp_accept[i]  ),
      .o_id     (o_mresp_id[i]      ),
      .o_data   (o_mresp_data[i]    ),
      .o_last   (o_mresp_last[i]    )
    );
  end
endmodule

// ==== rtl/resp_demux.sv ====
// resp_demux: destination decoder and valid/accept demultiplexer for the response head
`timescale 1ns/1ps

module resp_demux
  import resp_switch_pkg::*;
(
  input  var logic        i_head_valid,
  output var logic        o_head_accept,
  input  var resp_id_t    i_head_id,
  output var master_sel_t o_request,
  input  var master_sel_t i_grant,
  output var master_sel_t o_sw_valid,
  input  var master_sel_t i_sw_accept
);
  master_idx_t dest_idx;

  // the destination sits in the top bits of the id
  always_comb begin
    dest_idx = i_head_id[ID_W-1-:MASTER_IDX_W];
  end

  // one-hot request, nothing is requested while the head is empty
  always_comb begin
    o_request = '0;
    if (i_head_valid) begin
      o_request[dest_idx] = 1'b1;
    end
  end

  // the grant is one-hot, so only one master sees the head valid
  always_comb begin
    o_sw_valid = {MASTERS{i_head_valid}} & i_grant;
  end

  // accept comes back from the granted master only
  always_comb begin
    o_head_accept = |(i_grant & i_sw_accept);
  end
endmodule

// ==== rtl/resp_route_lock.sv ====
// route lock that holds a burst's one-hot destination until its last beat
`timescale 1ns/1ps

module resp_route_lock
  import resp_switch_pkg::*;
(
  input  var logic        i_clk,
  input  var logic        i_rst,
  input  var master_sel_t i_request,
  input  var logic        i_transfer,
  input  var logic        i_last,
  output var master_sel_t o_grant
);
  typedef enum logic {
    IDLE,
    LOCKED
  } route_state_t;

  route_state_t state;
  route_state_t state_next;
  master_sel_t  locked_grant;   // destination of the burst in flight

  // a new burst is routed by its own id, later beats by the saved route
  always_comb begin
    if (state == LOCKED) begin
      o_grant = locked_grant;
    end else begin
      o_grant = i_request;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // a single-beat burst leaves in one cycle and never locks
        if (i_transfer && !i_last) begin
          state_next = LOCKED;
        end
      end
      LOCKED: begin
        if (i_transfer && i_last) begin
          state_next = IDLE;  // the last beat is accepted and the route is free again
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // the first beat of a multi-beat burst fixes the route for the rest of it
  always_ff @(posedge i_clk) begin
    if ((state == IDLE) && i_transfer && !i_last) begin
      locked_grant <= i_request;
    end
  end
endmodule

// ==== rtl/resp_fifo.sv ====
// resp_fifo: response FIFO with registered outputs and valid/accept handshake on both sides
`timescale 1ns/1ps

module resp_fifo
  import resp_switch_pkg::*;
#(
  parameter int DEPTH = 2
)(
  input  var logic       i_clk,
  input  var logic       i_rst,
  input  var logic       i_valid,
  output var logic       o_accept,
  input  var resp_id_t   i_id,
  input  var resp_data_t i_data,
  input  var logic       i_last,
  output var logic       o_valid,
  input  var logic       i_accept,
  output var resp_id_t   o_id,
  output var resp_data_t o_data,
  output var logic       o_last
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  resp_id_t   mem_id   [DEPTH];
  resp_data_t mem_data [DEPTH];
  logic       mem_last [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;    // beats held in storage, the output stage not included

  logic push;
  logic pop;
  logic out_free;     // output stage is empty or is being drained this cycle
  logic load_in;      // incoming beat goes straight to the output stage
  logic load_mem;     // output stage is refilled from storage
  logic wr_mem;

  always_comb begin
    o_accept = (count != CNT_W'(DEPTH));
    push     = i_valid && o_accept;
    pop      = o_valid && i_accept;
    out_free = !o_valid || pop;
    load_mem = out_free && (count != '0);
    load_in  = push && out_free && (count == '0);  // storage empty, so order is kept
    wr_mem   = push && !load_in;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_valid <= 1'b0;
    end else begin
      if (wr_mem) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (load_mem) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_mem, load_mem})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // no change, or one in and one out
      endcase
      if (load_in || load_mem) begin
        o_valid <= 1'b1;
      end else if (pop) begin
        o_valid <= 1'b0;
      end
    end
  end

  // storage and the output stage hold payload only
  always_ff @(posedge i_clk) begin
    if (wr_mem) begin
      mem_id[wr_ptr]   <= i_id;
      mem_data[wr_ptr] <= i_data;
      mem_last[wr_ptr] <= i_last;
    end
    if (load_mem) begin
      o_id   <= mem_id[rd_ptr];
      o_data <= mem_data[rd_ptr];
      o_last <= mem_last[rd_ptr];
    end else if (load_in) begin
      o_id   <= i_id;
      o_data <= i_data;
      o_last <= i_last;
    end
  end
endmodule

// ==== rtl/resp_switch_pkg.sv ====
// response switch package: bus widths, master count, FIFO depths and vector typedefs
package resp_switch_pkg;

  // number of master ports behind the switch
  localparam int MASTERS      = 4;

  // width of the destination index carried in the top bits of the id
  localparam int MASTER_IDX_W = 2;

  // response id width, the upper MASTER_IDX_W bits select the master and
  // the remaining bits are a tag that the switch never looks at
  localparam int ID_W         = 6;

  localparam int DATA_W       = 32; // response data width

  // entries in the input FIFO, two are enough to keep one beat per cycle
  localparam int SLAVE_DEPTH  = 2;

  // entries in each output FIFO
  localparam int MASTER_DEPTH = 4;

  // response id, destination field on top and tag below
  typedef logic [ID_W-1:0]         resp_id_t;

  // response payload
  typedef logic [DATA_W-1:0]       resp_data_t;

  // one bit per master port, used one-hot for requests and grants
  typedef logic [MASTERS-1:0]      master_sel_t;

  // binary master index as it appears in the id
  typedef logic [MASTER_IDX_W-1:0] master_idx_t;

endpackage
